//--- verilog/hdmi_settings.svh
/*
 * Display path settings
 * Raster timing, framebuffer placement and scan line size.
 * Defaults are small to keep simulation short.
 */
`ifndef HDMI_SETTINGS_SVH
`define HDMI_SETTINGS_SVH

// Horizontal timing in pixel clocks, H_ACTIVE must be a multiple of 4
`define H_ACTIVE 16
`define H_FRONT 4
`define H_SYNC 6
`define H_BACK 8
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_ACTIVE 4
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// RGB565 line, two bytes per pixel
`define LINE_BYTES (2 * `H_ACTIVE)

// Byte address of pixel (0,0) in external memory
`define FB_BASE 24'h010000

`endif

//--- verilog/hdmi_pkg.sv
/*
 * Display path types
 * Pixel format and the two views of a 64-bit memory word.
 */
package hdmi_pkg;

// Red in the top bits
typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
} rgb565_t;

// Memory word seen as raw data or as four pixels, lane 0 lowest
typedef union packed {
    logic [63:0] raw;
    rgb565_t [3:0] pix;
} mem_word_u;

endpackage: hdmi_pkg

//--- verilog/video_sync.sv
/*
 * Raster timing generator
 * Pixel and line counters with registered sync strobes, data enable
 * and pixel coordinates.
 */
`timescale 1ns/1ns
`include "hdmi_settings.svh"

module video_sync
(
    input logic i_clk,                      // Pixel clock
    input logic i_arst_n,                   // Async reset active LOW
    output logic o_hsync,                   // Horizontal sync strobe
    output logic o_vsync,                   // Vertical sync strobe
    output logic o_de,                      // Active picture area
    output logic [10:0] o_x,
    output logic [9:0] o_y
);

localparam logic [10:0] X_LAST = 11'(`H_TOTAL - 1);
localparam logic [9:0] Y_LAST = 10'(`V_TOTAL - 1);
localparam logic [10:0] HS_START = 11'(`H_ACTIVE + `H_FRONT);
localparam logic [10:0] HS_END = 11'(`H_ACTIVE + `H_FRONT + `H_SYNC);
localparam logic [9:0] VS_START = 10'(`V_ACTIVE + `V_FRONT);
localparam logic [9:0] VS_END = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);

logic [10:0] r_cnt_x;
logic [9:0] r_cnt_y;
logic r_hsync;
logic r_vsync;
logic r_de;
logic [10:0] r_x;
logic [9:0] r_y;

always_ff @(posedge i_clk or negedge i_arst_n)
begin: cnt_proc
    if (!i_arst_n)
    begin
        r_cnt_x <= '0;
        r_cnt_y <= '0;
    end
    else if (r_cnt_x == X_LAST)
    begin
        r_cnt_x <= '0;
        r_cnt_y <= (r_cnt_y == Y_LAST) ? 10'd0 : r_cnt_y + 10'd1;   // Next line or next frame
    end
    else
    begin
        r_cnt_x <= r_cnt_x + 11'd1;
    end
end: cnt_proc

always_ff @(posedge i_clk or negedge i_arst_n)
begin: out_proc
    if (!i_arst_n)
    begin
        r_hsync <= 1'b0;
        r_vsync <= 1'b0;
        r_de <= 1'b0;
        // Position just before the first counted pixel
        r_x <= X_LAST;
        r_y <= Y_LAST;
    end
    else
    begin
        r_hsync <= (r_cnt_x >= HS_START) && (r_cnt_x < HS_END);
        r_vsync <= (r_cnt_y >= VS_START) && (r_cnt_y < VS_END);
        r_de <= (r_cnt_x < 11'(`H_ACTIVE)) && (r_cnt_y < 10'(`V_ACTIVE));
        r_x <= r_cnt_x;
        r_y <= r_cnt_y;
    end
end: out_proc

assign o_hsync = r_hsync;
assign o_vsync = r_vsync;
assign o_de = r_de;
assign o_x = r_x;
assign o_y = r_y;

// Framebuffer relies on every line start showing up as x equal to 0
x_range_chk: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_x < 11'(`H_TOTAL));

endmodule: video_sync

//--- verilog/rgb2ycbcr.sv
/*
 * RGB565 to YCbCr converter
 * BT.601 studio range, 6 bits per component, one register stage.
 */
`timescale 1ns/1ns

module rgb2ycbcr
(
    input logic i_clk,
    input logic i_arst_n,                   // Async reset active LOW
    input hdmi_pkg::rgb565_t i_pix,
    input logic i_de,
    output logic [17:0] o_ycbcr             // Y, Cb, Cr from high to low
);

logic [7:0] w_r8;
logic [7:0] w_g8;
logic [7:0] w_b8;
logic signed [17:0] w_r;
logic signed [17:0] w_g;
logic signed [17:0] w_b;
logic signed [17:0] w_y_sum;
logic signed [17:0] w_cb_sum;
logic signed [17:0] w_cr_sum;
logic signed [17:0] w_y;
logic signed [17:0] w_cb;
logic signed [17:0] w_cr;
logic [17:0] r_ycbcr;

// Top bits repeated so that full scale maps to 255
assign w_r8 = {i_pix.r, i_pix.r[4:2]};
assign w_g8 = {i_pix.g, i_pix.g[5:4]};
assign w_b8 = {i_pix.b, i_pix.b[4:2]};

assign w_r = {10'd0, w_r8};
assign w_g = {10'd0, w_g8};
assign w_b = {10'd0, w_b8};

assign w_y_sum = 18'sd66 * w_r + 18'sd129 * w_g + 18'sd25 * w_b + 18'sd128;
assign w_cb_sum = 18'sd112 * w_b - 18'sd38 * w_r - 18'sd74 * w_g + 18'sd128;
assign w_cr_sum = 18'sd112 * w_r - 18'sd94 * w_g - 18'sd18 * w_b + 18'sd128;

assign w_y = 18'sd16 + (w_y_sum >>> 8);     // 16..235
assign w_cb = 18'sd128 + (w_cb_sum >>> 8);  // Chroma centred on 128
assign w_cr = 18'sd128 + (w_cr_sum >>> 8);

always_ff @(posedge i_clk or negedge i_arst_n)
begin: out_proc
    if (!i_arst_n)
        r_ycbcr <= '0;
    else if (i_de)
        r_ycbcr <= {w_y[7:2], w_cb[7:2], w_cr[7:2]};
    else
        r_ycbcr <= '0;                      // Blank outside the active area
end: out_proc

assign o_ycbcr = r_ycbcr;

endmodule: rgb2ycbcr

//--- verilog/framebuf.sv
/*
 * Framebuffer line engine
 * Prefetches the next scan line into a ping-pong line buffer, reads the
 * current line back pixel by pixel and aligns syncs with the YCbCr output.
 */
`timescale 1ns/1ns
`include "hdmi_settings.svh"

module framebuf
(
    input logic i_clk,
    input logic i_arst_n,                   // Async reset active LOW
    input logic i_hsync,
    input logic i_vsync,
    input logic i_de,
    input logic [10:0] i_x,
    input logic [9:0] i_y,
    output logic o_hsync,
    output logic o_vsync,
    output logic o_de,
    output logic [17:0] o_ycbcr,
    input logic i_req_ready,
    output logic o_req_valid,
    output logic [23:0] o_req_addr,         // Byte offset of the requested line
    output logic [11:0] o_req_bytes,
    input logic i_resp_valid,
    input logic i_resp_last,
    input logic [23:0] i_resp_addr,
    input logic [63:0] i_resp_data,
    output logic o_resp_ready
);

import hdmi_pkg::*;

localparam int WORDS = `H_ACTIVE / 4;       // Buffer entries per line
localparam int AW = $clog2(2 * WORDS);
localparam logic [10:0] X_LAST = 11'(`H_TOTAL - 1);
localparam logic [9:0] Y_LAST = 10'(`V_TOTAL - 1);

mem_word_u lbuf [2 * WORDS];                // Two lines, four pixels per entry
logic r_rd_half;                            // Half shown on the current line
logic [AW-1:0] w_rd_idx;
logic [AW-1:0] w_wr_idx;
logic [23:0] w_wr_off;
logic w_line_start;
logic [9:0] w_next_y;
logic w_fetch;
logic w_resp_fire;
logic r_req_valid;
logic [23:0] r_req_addr;
logic r_burst;
logic r_resp_ready;
mem_word_u r_word;
logic [1:0] r_lane;
rgb565_t w_pix;
logic [1:0] r_hs_pipe;
logic [1:0] r_vs_pipe;
logic [1:0] r_de_pipe;

assign w_line_start = (i_x == 11'd0);
assign w_next_y = (i_y == Y_LAST) ? 10'd0 : i_y + 10'd1;
assign w_fetch = w_line_start && (w_next_y < 10'(`V_ACTIVE));
assign w_resp_fire = i_resp_valid && r_resp_ready;

// Words land in the idle half at their offset from the line start
assign w_wr_off = i_resp_addr - r_req_addr;
assign w_wr_idx = AW'((r_rd_half ? 0 : WORDS) + int'(w_wr_off[23:3]));
assign w_rd_idx = AW'((r_rd_half ? WORDS : 0) + int'(i_x[10:2]));

always_ff @(posedge i_clk or negedge i_arst_n)
begin: req_proc
    if (!i_arst_n)
    begin
        r_req_valid <= 1'b0;
        r_req_addr <= '0;
        r_burst <= 1'b0;
        r_resp_ready <= 1'b0;
        r_rd_half <= 1'b0;
    end
    else
    begin
        r_resp_ready <= 1'b1;
        if (i_x == X_LAST)
            r_rd_half <= ~r_rd_half;        // y advances on the next cycle
        if (w_fetch)
        begin
            r_req_valid <= 1'b1;
            r_req_addr <= 24'(w_next_y) * 24'(`LINE_BYTES);
        end
        else if (i_req_ready)
        begin
            r_req_valid <= 1'b0;
        end
        if (r_req_valid && i_req_ready)
            r_burst <= 1'b1;
        else if (w_resp_fire && i_resp_last)
            r_burst <= 1'b0;
    end
end: req_proc

always_ff @(posedge i_clk)
begin: wr_proc
    if (w_resp_fire)
        lbuf[w_wr_idx].raw <= i_resp_data;
end: wr_proc

always_ff @(posedge i_clk)
begin: rd_proc
    if (i_de)
    begin
        r_word <= lbuf[w_rd_idx];
        r_lane <= i_x[1:0];
    end
end: rd_proc

// Two stages, buffer read then color conversion
always_ff @(posedge i_clk or negedge i_arst_n)
begin: sync_proc
    if (!i_arst_n)
    begin
        r_hs_pipe <= '0;
        r_vs_pipe <= '0;
        r_de_pipe <= '0;
    end
    else
    begin
        r_hs_pipe <= {r_hs_pipe[0], i_hsync};
        r_vs_pipe <= {r_vs_pipe[0], i_vsync};
        r_de_pipe <= {r_de_pipe[0], i_de};
    end
end: sync_proc

assign w_pix = r_word.pix[r_lane];

rgb2ycbcr conv0 (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_pix(w_pix),
    .i_de(r_de_pipe[0]),
    .o_ycbcr(o_ycbcr)
);

assign o_hsync = r_hs_pipe[1];
assign o_vsync = r_vs_pipe[1];
assign o_de = r_de_pipe[1];
assign o_req_valid = r_req_valid;
assign o_req_addr = r_req_addr;
assign o_req_bytes = 12'(`LINE_BYTES);
assign o_resp_ready = r_resp_ready;

// Previous line fetch must be fully written before the halves swap again
underrun_chk: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    w_line_start |-> !(r_req_valid || r_burst));

endmodule: framebuf

//--- verilog/mem_reader.sv
/*
 * Burst read engine
 * Splits a line request into single 64-bit reads on the external memory
 * port and hands each word back with its offset address.
 */
`timescale 1ns/1ns
`include "hdmi_settings.svh"

module mem_reader
(
    input logic i_clk,
    input logic i_arst_n,                   // Async reset active LOW
    input logic i_req_valid,
    input logic [23:0] i_req_addr,          // Byte offset inside the framebuffer
    input logic [11:0] i_req_bytes,
    output logic o_req_ready,
    output logic o_resp_valid,
    output logic o_resp_last,
    output logic [23:0] o_resp_addr,
    output logic [63:0] o_resp_data,
    input logic i_resp_ready,
    output logic o_mem_rd,                  // One-cycle read strobe
    output logic [23:0] o_mem_addr,
    input logic i_mem_rvalid,
    input logic [63:0] i_mem_rdata
);

import hdmi_pkg::*;

localparam logic [1:0] ST_IDLE = 2'd0;
localparam logic [1:0] ST_READ = 2'd1;
localparam logic [1:0] ST_WAIT = 2'd2;
localparam logic [1:0] ST_RESP = 2'd3;

logic [1:0] r_state;
logic [23:0] r_addr;                        // Offset of the word in flight
logic [11:0] r_left;                        // Bytes left including this word
logic r_last;
mem_word_u r_data;

always_ff @(posedge i_clk or negedge i_arst_n)
begin: ctrl_proc
    if (!i_arst_n)
    begin
        r_state <= ST_IDLE;
        r_addr <= '0;
        r_left <= '0;
    end
    else
    begin
        case (r_state)
        ST_IDLE:
            if (i_req_valid)
            begin
                r_addr <= {i_req_addr[23:3], 3'b000};
                r_left <= i_req_bytes;
                r_state <= ST_READ;
            end
        ST_READ:
            r_state <= ST_WAIT;
        ST_WAIT:
            if (i_mem_rvalid)
                r_state <= ST_RESP;
        ST_RESP:
            if (i_resp_ready)
            begin
                if (r_last)
                begin
                    r_state <= ST_IDLE;
                end
                else
                begin
                    r_addr <= r_addr + 24'd8;
                    r_left <= r_left - 12'd8;
                    r_state <= ST_READ;         // Next word only after this one left
                end
            end
        default:
            r_state <= ST_IDLE;
        endcase
    end
end: ctrl_proc

always_ff @(posedge i_clk)
begin: data_proc
    if ((r_state == ST_WAIT) && i_mem_rvalid)
    begin
        r_data.raw <= i_mem_rdata;
        r_last <= (r_left <= 12'd8);
    end
end: data_proc

assign o_req_ready = (r_state == ST_IDLE);
assign o_mem_rd = (r_state == ST_READ);
assign o_mem_addr = r_addr + `FB_BASE;
assign o_resp_valid = (r_state == ST_RESP);
assign o_resp_last = r_last;
assign o_resp_addr = r_addr;
assign o_resp_data = r_data.raw;

// Stalled word is held unchanged until the framebuffer takes it
resp_stable_chk: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp_addr)
        && $stable(o_resp_last) && $stable(o_resp_data));

endmodule: mem_reader

//--- verilog/hdmi_top.sv
/*
 * Display output path
 * Raster timing, line prefetch framebuffer and memory read engine
 * feeding an HDMI transmitter with 18-bit YCbCr.
 */
`timescale 1ns/1ns

module hdmi_top
(
    input logic i_clk,                      // Pixel and system clock
    input logic i_arst_n,                   // Async reset active LOW
    input logic i_mem_rvalid,
    input logic [63:0] i_mem_rdata,
    output logic o_hsync,
    output logic o_vsync,
    output logic o_de,
    output logic [17:0] o_data,             // YCbCr to the transmitter
    output logic o_mem_rd,
    output logic [23:0] o_mem_addr
);

logic w_sync_hsync;
logic w_sync_vsync;
logic w_sync_de;
logic [10:0] wb_sync_x;
logic [9:0] wb_sync_y;
logic w_req_ready;
logic w_req_valid;
logic [23:0] wb_req_addr;
logic [11:0] wb_req_bytes;
logic w_resp_valid;
logic w_resp_last;
logic [23:0] wb_resp_addr;
logic [63:0] wb_resp_data;
logic w_resp_ready;

video_sync sync0 (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .o_hsync(w_sync_hsync),
    .o_vsync(w_sync_vsync),
    .o_de(w_sync_de),
    .o_x(wb_sync_x),
    .o_y(wb_sync_y)
);

framebuf fb0 (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_hsync(w_sync_hsync),
    .i_vsync(w_sync_vsync),
    .i_de(w_sync_de),
    .i_x(wb_sync_x),
    .i_y(wb_sync_y),
    .o_hsync(o_hsync),
    .o_vsync(o_vsync),
    .o_de(o_de),
    .o_ycbcr(o_data),
    .i_req_ready(w_req_ready),
    .o_req_valid(w_req_valid),
    .o_req_addr(wb_req_addr),
    .o_req_bytes(wb_req_bytes),
    .i_resp_valid(w_resp_valid),
    .i_resp_last(w_resp_last),
    .i_resp_addr(wb_resp_addr),
    .i_resp_data(wb_resp_data),
    .o_resp_ready(w_resp_ready)
);

mem_reader rd0 (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_req_valid(w_req_valid),
    .i_req_addr(wb_req_addr),
    .i_req_bytes(wb_req_bytes),
    .o_req_ready(w_req_ready),
    .o_resp_valid(w_resp_valid),
    .o_resp_last(w_resp_last),
    .o_resp_addr(wb_resp_addr),
    .o_resp_data(wb_resp_data),
    .i_resp_ready(w_resp_ready),
    .o_mem_rd(o_mem_rd),
    .o_mem_addr(o_mem_addr),
    .i_mem_rvalid(i_mem_rvalid),
    .i_mem_rdata(i_mem_rdata)
);

endmodule: hdmi_top

//--- testbench/tb_frame_memory.sv
/*
 * Frame memory model
 * Answers each read strobe with one word after 1 to 3 wait cycles,
 * or after 1 in fast mode. Contents follow from the byte address.
 */
`timescale 1ns/1ns

module tb_frame_memory
(
    input logic i_clk,
    input logic i_arst_n,
    input logic i_fast,                     // Latency fixed at 1
    input logic i_rd,
    input logic [23:0] i_addr,
    output logic o_rvalid,
    output logic [63:0] o_rdata
);

import hdmi_pkg::*;

logic [1:0] r_wait = 2'd0;                  // Wait cycles left
logic [23:0] r_addr = 24'd0;
logic r_rvalid = 1'b0;
mem_word_u r_word = '0;

function automatic logic [15:0] pixel_at(input logic [23:0] a);
    return a[16:1] ^ 16'h5a3c;
endfunction

always @(posedge i_clk or negedge i_arst_n)
begin
    if (!i_arst_n)
    begin
        r_wait <= 2'd0;
        r_rvalid <= 1'b0;
        r_word.raw <= '0;
    end
    else
    begin
        r_rvalid <= 1'b0;
        if (i_rd)
        begin
            r_addr <= {i_addr[23:3], 3'b000};
            r_wait <= i_fast ? 2'd1 : 2'(($urandom % 3) + 1);
        end
        else if (r_wait != 2'd0)
        begin
            r_wait <= r_wait - 2'd1;
            if (r_wait == 2'd1)
            begin
                r_rvalid <= 1'b1;
                // Lane 0 holds the pixel at the lowest address
                r_word.raw <= {pixel_at(r_addr + 24'd6), pixel_at(r_addr + 24'd4),
                    pixel_at(r_addr + 24'd2), pixel_at(r_addr)};
            end
        end
    end
end

assign o_rvalid = r_rvalid;
assign o_rdata = r_word.raw;

endmodule: tb_frame_memory

//--- testbench/tb_hdmi_top.sv
/*
 * Testbench for the display output path
 * Directed tests of reset, raster timing, line fetch order, blanking and
 * pixel data with fast and with random memory latency.
 */
`timescale 1ns/1ns
`include "hdmi_settings.svh"

module tb_hdmi_top;

localparam int WPL = `LINE_BYTES / 8;      // Memory words per line
localparam int FRAME = `H_TOTAL * `V_TOTAL;
localparam int PIXELS = `H_ACTIVE * `V_ACTIVE;
localparam int LIMIT = 2 * FRAME;           // Cycles before a wait gives up
localparam int SIG_VSYNC = 0;
localparam int SIG_DE = 1;
localparam int SIG_RD = 2;

logic clk;
logic arst_n;
logic fast;
logic mem_rvalid;
logic [63:0] mem_rdata;
logic hsync;
logic vsync;
logic de;
logic [17:0] data;
logic mem_rd;
logic [23:0] mem_addr;
int errors;
int checks;
int tests;
int failed;
int test_err;                               // Error count when the test began
int unsigned seed;
int unsigned rnd;
logic [17:0] fast_frame [PIXELS];
logic [17:0] cur_frame [PIXELS];

hdmi_top uut (
    .i_clk(clk),
    .i_arst_n(arst_n),
    .i_mem_rvalid(mem_rvalid),
    .i_mem_rdata(mem_rdata),
    .o_hsync(hsync),
    .o_vsync(vsync),
    .o_de(de),
    .o_data(data),
    .o_mem_rd(mem_rd),
    .o_mem_addr(mem_addr)
);

tb_frame_memory mem0 (
    .i_clk(clk),
    .i_arst_n(arst_n),
    .i_fast(fast),
    .i_rd(mem_rd),
    .i_addr(mem_addr),
    .o_rvalid(mem_rvalid),
    .o_rdata(mem_rdata)
);

always #5 clk = ~clk;

function automatic logic [15:0] pixel_at(input logic [23:0] a);
    return a[16:1] ^ 16'h5a3c;
endfunction

// BT.601 studio range, top 6 bits of each 8-bit component
function automatic logic [17:0] expected_ycbcr(input logic [15:0] p);
    int r;
    int g;
    int b;
    int y;
    int cb;
    int cr;
    r = p[15:11];
    g = p[10:5];
    b = p[4:0];
    r = r * 8 + r / 4;
    g = g * 4 + g / 16;
    b = b * 8 + b / 4;
    y = 16 + ((66 * r + 129 * g + 25 * b + 128) >>> 8);
    cb = 128 + ((-38 * r - 74 * g + 112 * b + 128) >>> 8);
    cr = 128 + ((112 * r - 94 * g - 18 * b + 128) >>> 8);
    return {6'(y / 4), 6'(cb / 4), 6'(cr / 4)};
endfunction

function automatic logic signal_value(input int sel);
    case (sel)
        SIG_VSYNC: return vsync;
        SIG_DE: return de;
        default: return mem_rd;
    endcase
endfunction

task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
endtask

// Steps whole cycles, so a level already present on entry is not taken
task automatic wait_until(input int sel, input string name, input logic level,
    output logic ok);
    int n;
    n = 0;
    do
    begin
        @(negedge clk);
        n++;
    end
    while (signal_value(sel) !== level && n < LIMIT);
    ok = (signal_value(sel) === level);
    if (!ok)
    begin
        errors++;
        $display("Timed out after %0d cycles waiting for %s to be %0b", n, name, level);
    end
endtask

// Returns on the first active pixel of a frame
task automatic find_frame_start(output logic ok);
    wait_until(SIG_VSYNC, "o_vsync", 1'b1, ok);
    if (ok)
        wait_until(SIG_VSYNC, "o_vsync", 1'b0, ok);
    if (ok)
        wait_until(SIG_DE, "o_de", 1'b1, ok);
endtask

task automatic report_test(input string name);
    tests++;
    if (errors == test_err)
    begin
        $display("%s: ok", name);
    end
    else
    begin
        failed++;
        $display("%s: %0d errors", name, errors - test_err);
    end
endtask

task automatic test_reset();
    test_err = errors;
    repeat (5)
    begin
        @(negedge clk);
        check_equal("o_hsync", hsync, 0);
        check_equal("o_vsync", vsync, 0);
        check_equal("o_de", de, 0);
        check_equal("o_data", data, 0);
        check_equal("o_mem_rd", mem_rd, 0);
    end
    @(posedge clk);
    arst_n <= 1'b1;
    report_test("reset");
endtask

task automatic test_sync_timing();
    logic ok;
    logic vs_seen;
    int de_cnt;
    int hs_cnt;
    int hs_pos;
    int de_lines;
    int vs_lines;
    test_err = errors;
    de_lines = 0;
    vs_lines = 0;
    find_frame_start(ok);
    for (int ly = 0; ly < `V_TOTAL && ok; ly++)
    begin
        de_cnt = 0;
        hs_cnt = 0;
        hs_pos = -1;
        vs_seen = 1'b0;
        for (int lx = 0; lx < `H_TOTAL; lx++)
        begin
            if (ly != 0 || lx != 0)
                @(negedge clk);
            if (de === 1'b1)
                de_cnt++;
            if (hsync === 1'b1)
            begin
                if (hs_pos < 0)
                    hs_pos = lx;            // Counted from the line's de rise
                hs_cnt++;
            end
            if (vsync === 1'b1)
                vs_seen = 1'b1;
        end
        check_equal("o_de cycles in line", de_cnt, (ly < `V_ACTIVE) ? `H_ACTIVE : 0);
        check_equal("o_hsync cycles in line", hs_cnt, `H_SYNC);
        check_equal("o_hsync rise position", hs_pos, `H_ACTIVE + `H_FRONT);
        if (de_cnt > 0)
            de_lines++;
        if (vs_seen)
            vs_lines++;
    end
    check_equal("o_de lines per frame", de_lines, `V_ACTIVE);
    check_equal("o_vsync lines per frame", vs_lines, `V_SYNC);
    report_test("sync timing");
endtask

// Line 0 is fetched during the last blank line, so lines come in order from vsync
task automatic test_fetch_order();
    logic ok;
    test_err = errors;
    wait_until(SIG_VSYNC, "o_vsync", 1'b1, ok);
    for (int i = 0; i < `V_ACTIVE * WPL && ok; i++)
    begin
        wait_until(SIG_RD, "o_mem_rd", 1'b1, ok);
        if (ok)
            check_equal("o_mem_addr", mem_addr,
                `FB_BASE + (i / WPL) * `LINE_BYTES + (i % WPL) * 8);
    end
    report_test("fetch order");
endtask

task automatic test_blanking();
    int lo_cnt;
    test_err = errors;
    lo_cnt = 0;
    for (int i = 0; i < FRAME; i++)
    begin
        @(negedge clk);
        if (de !== 1'b1)
        begin
            lo_cnt++;
            check_equal("o_data", data, 0);
        end
    end
    check_equal("o_de low cycles per frame", lo_cnt, FRAME - PIXELS);
    report_test("blanking");
endtask

task automatic scan_frame();
    logic ok;
    logic [23:0] a;
    find_frame_start(ok);
    for (int y = 0; y < `V_ACTIVE && ok; y++)
    begin
        if (y > 0)
            wait_until(SIG_DE, "o_de", 1'b1, ok);
        for (int x = 0; x < `H_ACTIVE && ok; x++)
        begin
            if (x > 0)
                @(negedge clk);
            a = `FB_BASE + y * `LINE_BYTES + 2 * x;
            check_equal("o_de", de, 1'b1);
            check_equal("o_data", data, expected_ycbcr(pixel_at(a)));
            cur_frame[y * `H_ACTIVE + x] = data;
        end
    end
endtask

task automatic test_pixels_fast();
    test_err = errors;
    scan_frame();
    for (int i = 0; i < PIXELS; i++)
        fast_frame[i] = cur_frame[i];
    report_test("pixels, fast memory");
endtask

task automatic test_pixels_random();
    test_err = errors;
    @(posedge clk);
    fast <= 1'b0;
    repeat (2)
    begin
        scan_frame();
        for (int i = 0; i < PIXELS; i++)
            check_equal("o_data against fast run", cur_frame[i], fast_frame[i]);
    end
    report_test("pixels, random latency");
endtask

initial
begin
    clk = 1'b0;
    arst_n = 1'b0;
    fast = 1'b1;
    errors = 0;
    checks = 0;
    tests = 0;
    failed = 0;
    seed = 32'hdc544c69;
    rnd = $urandom(seed);
    test_reset();
    test_sync_timing();
    test_fetch_order();
    test_blanking();
    test_pixels_fast();
    test_pixels_random();
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
    if (errors == 0)
        $display("sim passed");
    else
        $display("sim failed");
    $finish;
end

endmodule: tb_hdmi_top

//--- all.f
+incdir+verilog
verilog/hdmi_pkg.sv
verilog/video_sync.sv
verilog/rgb2ycbcr.sv
verilog/framebuf.sv
verilog/mem_reader.sv
verilog/hdmi_top.sv
testbench/tb_frame_memory.sv
testbench/tb_hdmi_top.sv
